// ==== hw/coreTypesPkg.sv ====
package coreTypesPkg;

localparam int XLEN = 32;
localparam int SQN_W = 7;   // ages compare by signed difference.
localparam int TAG_W = 6;
localparam int REG_W = 5;   // reg 0 means no destination.

localparam int SHAMT_W = $clog2(XLEN);
localparam int CNT_W = $clog2(XLEN + 1);   // bit counts reach XLEN.

localparam int RECOVER_CYCLES = 3;
localparam int RT_W = $clog2(RECOVER_CYCLES + 1);

// values 8 to 15 come straight from the SYS immediate.
typedef enum logic [3:0] {
    NONE        = 4'd0,
    BRANCH      = 4'd1,
    PRED_TAKEN  = 4'd2,
    PRED_NTAKEN = 4'd3
} ResFlags;

endpackage

// ==== hw/intOpPkg.sv ====
package intOpPkg;

// alu-only ops first, then SYS, jumps, and the branch range last.
typedef enum logic [5:0] {
    ADD, SUB, XOR, OR, AND, ANDN,
    SLL, SRL, SRA,
    SLT, SLTU,
    LUI, AUIPC,
    SH1ADD, SH2ADD,
    CLZ, CTZ, CPOP,
    MIN, MAX, MINU, MAXU,
    REV8, SE_B, ZE_H,
    SYS,
    JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU
} IntOp;

typedef enum logic {
    RUN,
    RECOVER
} CtrlState;

function automatic logic isAluOp(IntOp op);
    return op <= ZE_H;
endfunction

function automatic logic isJump(IntOp op);
    return op == JAL || op == JALR;
endfunction

function automatic logic isCondBranch(IntOp op);
    return op >= BEQ && op <= BGEU;   // contiguous range.
endfunction

endpackage

// ==== hw/intAlu.sv ====
`timescale 1ns/10ps

module intAlu import coreTypesPkg::*, intOpPkg::*; (
    input IntOp op,
    input logic [XLEN-1:0] srcA,
    input logic [XLEN-1:0] srcB,
    input logic [XLEN-1:0] imm,
    input logic [XLEN-1:0] pc,
    input logic compressed,
    output logic [XLEN-1:0] result,
    output logic lessThan,
    output logic lessThanU
);

logic [XLEN-1:0] srcARev;
logic [XLEN-1:0] lzIn;
logic [CNT_W-1:0] lzCnt;
logic [CNT_W-1:0] popCnt;
logic [XLEN-1:0] linkPc;

assign lessThan = $signed(srcA) < $signed(srcB);
assign lessThanU = srcA < srcB;
assign linkPc = compressed ? pc + 2 : pc + 4;

always_comb begin
    for (int i = 0; i < XLEN; i++) begin
        srcARev[i] = srcA[XLEN-1-i];
    end
end

// trailing zeros are leading zeros of the reversed word.
assign lzIn = (op == CTZ) ? srcARev : srcA;

always_comb begin
    lzCnt = CNT_W'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
        if (lzIn[i]) begin
            lzCnt = CNT_W'(XLEN - 1 - i);   // highest set bit wins.
        end
    end
end

always_comb begin
    popCnt = '0;
    for (int i = 0; i < XLEN; i++) begin
        popCnt = popCnt + CNT_W'(srcA[i]);
    end
end

always_comb begin
    result = '0;
    if (isJump(op)) begin
        result = linkPc;   // link address.
    end else if (isAluOp(op)) begin
        case (op)
            ADD:    result = srcA + srcB;
            SUB:    result = srcA - srcB;
            XOR:    result = srcA ^ srcB;
            OR:     result = srcA | srcB;
            AND:    result = srcA & srcB;
            ANDN:   result = srcA & ~srcB;
            SLL:    result = srcA << srcB[SHAMT_W-1:0];
            SRL:    result = srcA >> srcB[SHAMT_W-1:0];
            SRA:    result = $signed(srcA) >>> srcB[SHAMT_W-1:0];
            SLT:    result = {{(XLEN-1){1'b0}}, lessThan};
            SLTU:   result = {{(XLEN-1){1'b0}}, lessThanU};
            LUI:    result = srcB;   // upper immediate arrives as operand.
            AUIPC:  result = pc + imm;
            SH1ADD: result = srcB + (srcA << 1);
            SH2ADD: result = srcB + (srcA << 2);
            CLZ,
            CTZ:    result = {{(XLEN-CNT_W){1'b0}}, lzCnt};
            CPOP:   result = {{(XLEN-CNT_W){1'b0}}, popCnt};
            MIN:    result = lessThan ? srcA : srcB;
            MAX:    result = lessThan ? srcB : srcA;
            MINU:   result = lessThanU ? srcA : srcB;
            MAXU:   result = lessThanU ? srcB : srcA;
            REV8:   result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            SE_B:   result = {{24{srcA[7]}}, srcA[7:0]};
            ZE_H:   result = {16'b0, srcA[15:0]};
            default: result = '0;
        endcase
    end
end

endmodule

// ==== hw/branchResolve.sv ====
`timescale 1ns/10ps

module branchResolve import coreTypesPkg::*, intOpPkg::*; (
    input IntOp op,
    input logic [XLEN-1:0] srcA,
    input logic [XLEN-1:0] srcB,
    input logic [XLEN-1:0] imm,
    input logic [XLEN-1:0] pc,
    input logic compressed,
    input logic predicted,
    input logic predTaken,
    input logic lessThan,
    input logic lessThanU,
    output logic isBranch,
    output logic mispredict,
    output logic [XLEN-1:0] dstPc,
    output logic btValid,
    output logic [XLEN-1:0] btSrc,
    output logic [XLEN-1:0] btDst,
    output logic btIsJump,
    output ResFlags flags
);

logic condBr;
logic taken;
logic [XLEN-1:0] linkPc;
logic [XLEN-1:0] brTarget;

assign condBr = isCondBranch(op);
assign isBranch = condBr || isJump(op);
assign linkPc = compressed ? pc + 2 : pc + 4;
assign brTarget = pc + {{(XLEN-13){imm[12]}}, imm[12:0]};

always_comb begin
    case (op)
        JAL,
        JALR: taken = 1'b1;
        BEQ:  taken = srcA == srcB;
        BNE:  taken = srcA != srcB;
        BLT:  taken = lessThan;
        BGE:  taken = !lessThan;
        BLTU: taken = lessThanU;
        BGEU: taken = !lessThanU;
        default: taken = 1'b0;
    endcase
end

always_comb begin
    if (op == JALR) begin
        dstPc = srcA + srcB;
    end else if (op == JAL) begin
        dstPc = pc + imm;
    end else begin
        dstPc = taken ? brTarget : linkPc;   // fall-through when not taken.
    end
end

// jalr is never predicted, so it always redirects.
assign mispredict = isBranch && ((condBr && taken != predTaken) || op == JALR);

assign btValid = (condBr || op == JAL) && taken && !predicted;
assign btSrc = compressed ? pc : pc + 2;   // 32-bit ops are found by their second half.
assign btDst = dstPc;
assign btIsJump = op == JAL;

always_comb begin
    if (condBr && predicted) begin
        flags = taken ? PRED_TAKEN : PRED_NTAKEN;
    end else if (condBr) begin
        flags = BRANCH;
    end else if (op == SYS) begin
        flags = ResFlags'(imm[3:0]);
    end else begin
        flags = NONE;
    end
end

endmodule

// ==== hw/recoveryTimer.sv ====
`timescale 1ns/10ps

module recoveryTimer import coreTypesPkg::*; (
    input logic clk,
    input logic rst,
    input logic start,
    output logic done
);

logic [RT_W-1:0] cnt;

// done lands in the last cycle of the window.
always_ff @(posedge clk) begin
    if (!rst) begin
        cnt <= '0;
    end else if (start) begin
        cnt <= RT_W'(RECOVER_CYCLES - 1);   // restart reloads.
    end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
    end
end

assign done = cnt == '0;

endmodule

// ==== hw/execCtrl.sv ====
`timescale 1ns/10ps

module execCtrl import coreTypesPkg::*, intOpPkg::*; (
    input logic clk,
    input logic rst,
    input logic valid,
    input logic en,
    input logic wbStall,
    input logic [SQN_W-1:0] sqN,
    input logic invalidate,
    input logic [SQN_W-1:0] invalidateSqN,
    input logic mispredict,
    input logic recoverDone,
    output logic accept,
    output logic timerStart,
    output CtrlState state
);

logic [SQN_W-1:0] recSqN;   // mispredicted branch.
logic signed [SQN_W-1:0] invAge;
logic signed [SQN_W-1:0] recAge;
logic killInv;
logic killRec;

// positive difference means younger.
assign invAge = sqN - invalidateSqN;
assign recAge = sqN - recSqN;

assign killInv = invalidate && invAge > 0;
assign killRec = (state == RECOVER) && recAge > 0;

assign accept = valid && en && !wbStall && !killInv && !killRec;
assign timerStart = accept && mispredict;

always_ff @(posedge clk) begin
    if (!rst) begin
        state <= RUN;
    end else if (timerStart) begin
        state <= RECOVER;   // also restarts an open window.
    end else if (state == RECOVER && recoverDone) begin
        state <= RUN;
    end
end

always_ff @(posedge clk) begin
    if (timerStart) begin
        recSqN <= sqN;
    end
end

endmodule

// ==== hw/resultStage.sv ====
`timescale 1ns/10ps

module resultStage import coreTypesPkg::*; (
    input logic clk,
    input logic rst,
    input logic accept,
    input logic [XLEN-1:0] result,
    input logic [TAG_W-1:0] tagDst,
    input logic [REG_W-1:0] regDst,
    input logic [SQN_W-1:0] sqN,
    input ResFlags flags,
    input logic mispredict,
    input logic [XLEN-1:0] dstPc,
    input logic btReqValid,
    input logic [XLEN-1:0] btReqSrc,
    input logic [XLEN-1:0] btReqDst,
    input logic btReqIsJump,
    output logic resValid,
    output logic [XLEN-1:0] resData,
    output logic [TAG_W-1:0] resTag,
    output logic [REG_W-1:0] resReg,
    output logic [SQN_W-1:0] resSqN,
    output ResFlags resFlags,
    output logic brTaken,
    output logic [SQN_W-1:0] brSqN,
    output logic [XLEN-1:0] brDstPc,
    output logic btValid,
    output logic [XLEN-1:0] btSrc,
    output logic [XLEN-1:0] btDst,
    output logic btIsJump
);

// strobes last one cycle.
always_ff @(posedge clk) begin
    if (!rst) begin
        resValid <= 1'b0;
        brTaken <= 1'b0;
        btValid <= 1'b0;
    end else begin
        resValid <= accept;
        brTaken <= accept && mispredict;
        btValid <= accept && btReqValid;
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        resData <= result;
        resTag <= tagDst;
        resReg <= regDst;
        resSqN <= sqN;
        resFlags <= flags;
        brSqN <= sqN;
        brDstPc <= dstPc;
        btSrc <= btReqSrc;
        btDst <= btReqDst;
        btIsJump <= btReqIsJump;
    end
end

endmodule

// ==== hw/intExecUnit.sv ====
`timescale 1ns/10ps

module intExecUnit import coreTypesPkg::*, intOpPkg::*; (
    input logic clk,
    input logic rst,
    input logic valid,
    input IntOp op,
    input logic [XLEN-1:0] srcA,
    input logic [XLEN-1:0] srcB,
    input logic [XLEN-1:0] imm,
    input logic [XLEN-1:0] pc,
    input logic compressed,
    input logic predicted,
    input logic predTaken,
    input logic [SQN_W-1:0] sqN,
    input logic [TAG_W-1:0] tagDst,
    input logic [REG_W-1:0] regDst,
    input logic en,
    input logic wbStall,
    input logic invalidate,
    input logic [SQN_W-1:0] invalidateSqN,
    output logic wbReq,
    output logic resValid,
    output logic [XLEN-1:0] resData,
    output logic [TAG_W-1:0] resTag,
    output logic [REG_W-1:0] resReg,
    output logic [SQN_W-1:0] resSqN,
    output ResFlags resFlags,
    output logic brTaken,
    output logic [SQN_W-1:0] brSqN,
    output logic [XLEN-1:0] brDstPc,
    output logic btValid,
    output logic [XLEN-1:0] btSrc,
    output logic [XLEN-1:0] btDst,
    output logic btIsJump
);

logic [XLEN-1:0] result;
logic lessThan;
logic lessThanU;
logic mispredict;
logic [XLEN-1:0] dstPc;
logic btReqValid;
logic [XLEN-1:0] btReqSrc;
logic [XLEN-1:0] btReqDst;
logic btReqIsJump;
ResFlags flags;
logic accept;
logic timerStart;
logic recoverDone;

assign wbReq = valid && en;   // independent of stall.

intAlu i_intAlu (
    .op(op),
    .srcA(srcA),
    .srcB(srcB),
    .imm(imm),
    .pc(pc),
    .compressed(compressed),
    .result(result),
    .lessThan(lessThan),
    .lessThanU(lessThanU)
);

branchResolve i_branchResolve (
    .op(op),
    .srcA(srcA),
    .srcB(srcB),
    .imm(imm),
    .pc(pc),
    .compressed(compressed),
    .predicted(predicted),
    .predTaken(predTaken),
    .lessThan(lessThan),
    .lessThanU(lessThanU),
    .isBranch(),
    .mispredict(mispredict),
    .dstPc(dstPc),
    .btValid(btReqValid),
    .btSrc(btReqSrc),
    .btDst(btReqDst),
    .btIsJump(btReqIsJump),
    .flags(flags)
);

execCtrl i_execCtrl (
    .clk(clk),
    .rst(rst),
    .valid(valid),
    .en(en),
    .wbStall(wbStall),
    .sqN(sqN),
    .invalidate(invalidate),
    .invalidateSqN(invalidateSqN),
    .mispredict(mispredict),
    .recoverDone(recoverDone),
    .accept(accept),
    .timerStart(timerStart),
    .state()
);

recoveryTimer i_recoveryTimer (
    .clk(clk),
    .rst(rst),
    .start(timerStart),
    .done(recoverDone)
);

resultStage i_resultStage (
    .clk(clk),
    .rst(rst),
    .accept(accept),
    .result(result),
    .tagDst(tagDst),
    .regDst(regDst),
    .sqN(sqN),
    .flags(flags),
    .mispredict(mispredict),
    .dstPc(dstPc),
    .btReqValid(btReqValid),
    .btReqSrc(btReqSrc),
    .btReqDst(btReqDst),
    .btReqIsJump(btReqIsJump),
    .resValid(resValid),
    .resData(resData),
    .resTag(resTag),
    .resReg(resReg),
    .resSqN(resSqN),
    .resFlags(resFlags),
    .brTaken(brTaken),
    .brSqN(brSqN),
    .brDstPc(brDstPc),
    .btValid(btValid),
    .btSrc(btSrc),
    .btDst(btDst),
    .btIsJump(btIsJump)
);

endmodule

// ==== sim/intExecUnitTb.sv ====
`timescale 1ns/10ps

module intExecUnitTb import coreTypesPkg::*, intOpPkg::*; ();

typedef struct {
    IntOp op;
    logic [XLEN-1:0] a, b, imm, pc;
    logic c, pd, pt;
    logic [SQN_W-1:0] sq;
    logic val, en, stall, inv;
    logic [SQN_W-1:0] invSq;
    logic acc;
    logic [XLEN-1:0] data;
    ResFlags fl;
    logic br;
    logic [XLEN-1:0] dst;
    logic bt;
    logic [XLEN-1:0] btSrcExp;
} Row;

logic clk, rst, valid, compressed, predicted, predTaken, en, wbStall, invalidate;
IntOp op;
logic [XLEN-1:0] srcA, srcB, imm, pc;
logic [SQN_W-1:0] sqN, invalidateSqN;
logic [TAG_W-1:0] tagDst;
logic [REG_W-1:0] regDst;
logic wbReq, resValid, brTaken, btValid, btIsJump;
logic [XLEN-1:0] resData, brDstPc, btSrc, btDst;
logic [TAG_W-1:0] resTag;
logic [REG_W-1:0] resReg;
logic [SQN_W-1:0] resSqN, brSqN;
ResFlags resFlags;

Row rows[$];
Row r;
logic [SQN_W-1:0] nextSq = 7'd10;
int cycles = 0;
int limit = 0;

intExecUnit i_intExecUnit (.*);

initial clk = 1'b0;
always #10 clk = ~clk;

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Test failures found");
        $fatal(1, "timeout");
    end
end

function automatic logic [XLEN-1:0] refAlu(IntOp o, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                           logic [XLEN-1:0] im, logic [XLEN-1:0] p);
    logic [XLEN-1:0] n;
    logic found;
    n = '0;
    found = 1'b0;
    case (o)
        ADD:    n = a + b;
        SUB:    n = a - b;
        XOR:    n = a ^ b;
        OR:     n = a | b;
        AND:    n = a & b;
        ANDN:   n = a & ~b;
        SLL:    n = a << b[4:0];
        SRL:    n = a >> b[4:0];
        SRA:    n = $signed(a) >>> b[4:0];
        SLT:    n = {31'b0, $signed(a) < $signed(b)};
        SLTU:   n = {31'b0, a < b};
        LUI:    n = b;
        AUIPC:  n = p + im;
        SH1ADD: n = (a << 1) + b;
        SH2ADD: n = (a << 2) + b;
        CLZ: for (int i = XLEN - 1; i >= 0; i--) begin
            if (!found) begin
                if (a[i]) found = 1'b1;
                else n = n + 1;
            end
        end
        CTZ: for (int i = 0; i < XLEN; i++) begin
            if (!found) begin
                if (a[i]) found = 1'b1;
                else n = n + 1;
            end
        end
        CPOP:   n = $countones(a);
        MIN:    n = ($signed(a) < $signed(b)) ? a : b;
        MAX:    n = ($signed(a) > $signed(b)) ? a : b;
        MINU:   n = (a < b) ? a : b;
        MAXU:   n = (a > b) ? a : b;
        REV8:   n = {a[7:0], a[15:8], a[23:16], a[31:24]};
        SE_B:   n = {{24{a[7]}}, a[7:0]};
        ZE_H:   n = {16'b0, a[15:0]};
        JAL, JALR: n = p + 32'd4;
        default: n = '0;   // branches and SYS write nothing useful.
    endcase
    return n;
endfunction

function automatic logic refTaken(IntOp o, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (o)
        BEQ:  return a == b;
        BNE:  return a != b;
        BLT:  return $signed(a) < $signed(b);
        BGE:  return $signed(a) >= $signed(b);
        BLTU: return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic Row aluRow(IntOp o, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                              logic [XLEN-1:0] im);
    Row x;
    x.op = o;
    x.a = a;
    x.b = b;
    x.imm = im;
    x.pc = 32'h1000;
    x.c = 1'b0;
    x.pd = 1'b0;
    x.pt = 1'b0;
    x.sq = nextSq;
    nextSq = nextSq + 7'd1;
    x.val = 1'b1;
    x.en = 1'b1;
    x.stall = 1'b0;
    x.inv = 1'b0;
    x.invSq = '0;
    x.acc = 1'b1;
    x.data = refAlu(o, a, b, im, x.pc);
    x.fl = NONE;
    x.br = 1'b0;
    x.dst = '0;
    x.bt = 1'b0;
    x.btSrcExp = '0;
    return x;
endfunction

// one older op passes, two younger ones are dropped, then the window closes.
task automatic addWindow(logic [SQN_W-1:0] s);
    Row x;
    x = aluRow(ADD, 32'd1, 32'd2, '0);
    x.sq = s - 7'd2;
    rows.push_back(x);
    x = aluRow(ADD, 32'd3, 32'd4, '0);
    x.sq = s + 7'd1;
    x.acc = 1'b0;
    rows.push_back(x);
    x = aluRow(XOR, 32'd5, 32'd6, '0);
    x.sq = s + 7'd2;
    x.acc = 1'b0;
    rows.push_back(x);
endtask

task automatic addBranch(IntOp o, logic [XLEN-1:0] a, logic [XLEN-1:0] b, logic pd, logic pt);
    Row x;
    logic tk;
    x = aluRow(o, a, b, pd ? 32'h0000_0ff0 : 32'h0000_1ff0);
    tk = refTaken(o, a, b);
    x.pd = pd;
    x.pt = pt;
    x.data = '0;
    x.fl = pd ? (tk ? PRED_TAKEN : PRED_NTAKEN) : BRANCH;
    x.br = tk != pt;
    x.dst = tk ? x.pc + {{19{x.imm[12]}}, x.imm[12:0]} : x.pc + 32'd4;
    x.bt = tk && !pd;
    x.btSrcExp = x.pc + 32'd2;
    rows.push_back(x);
    if (x.br) addWindow(x.sq);
endtask

task automatic checkData(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    if (exp !== act) begin
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "data mismatch");
    end
endtask

task automatic checkFlags(string name, ResFlags exp, ResFlags act);
    if (exp !== act) begin
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "flags mismatch");
    end
endtask

task automatic checkBit(string name, logic exp, logic act);
    if (exp !== act) begin
        $display("ERROR %0t %s expected %b got %b", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "strobe mismatch");
    end
endtask

task automatic checkSqN(string name, logic [SQN_W-1:0] exp, logic [SQN_W-1:0] act);
    if (exp !== act) begin
        $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "sequence number mismatch");
    end
endtask

task automatic checkTag(string name, logic [TAG_W-1:0] exp, logic [TAG_W-1:0] act);
    if (exp !== act) begin
        $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "tag mismatch");
    end
endtask

task automatic checkReg(string name, logic [REG_W-1:0] exp, logic [REG_W-1:0] act);
    if (exp !== act) begin
        $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "register mismatch");
    end
endtask

task automatic checkState(string name, CtrlState exp, CtrlState act);
    if (exp !== act) begin
        $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "state mismatch");
    end
endtask

task automatic checkIdle();
    checkBit("resValid", 1'b0, resValid);
    checkBit("brTaken", 1'b0, brTaken);
    checkBit("btValid", 1'b0, btValid);
    checkState("state", RUN, i_intExecUnit.i_execCtrl.state);
endtask

task automatic checkRow(Row x);
    checkBit("resValid", x.acc, resValid);
    checkBit("brTaken", x.acc && x.br, brTaken);
    checkBit("btValid", x.acc && x.bt, btValid);
    if (x.acc) begin
        checkData("resData", x.data, resData);
        checkFlags("resFlags", x.fl, resFlags);
        checkSqN("resSqN", x.sq, resSqN);
        checkTag("resTag", x.sq[TAG_W-1:0], resTag);
        checkReg("resReg", x.sq[REG_W-1:0], resReg);
        if (x.br) begin
            checkData("brDstPc", x.dst, brDstPc);
            checkSqN("brSqN", x.sq, brSqN);
        end
        if (x.bt) begin
            checkData("btSrc", x.btSrcExp, btSrc);
            checkData("btDst", x.dst, btDst);
            checkBit("btIsJump", x.op == JAL, btIsJump);
        end
    end
endtask

task automatic applyRow(Row x);
    op = x.op;
    srcA = x.a;
    srcB = x.b;
    imm = x.imm;
    pc = x.pc;
    compressed = x.c;
    predicted = x.pd;
    predTaken = x.pt;
    sqN = x.sq;
    tagDst = x.sq[TAG_W-1:0];
    regDst = x.sq[REG_W-1:0];
    valid = x.val;
    en = x.en;
    wbStall = x.stall;
    invalidate = x.inv;
    invalidateSqN = x.invSq;
endtask

// jalr always redirects.
task automatic applyRedirect();
    Row x;
    x = aluRow(JALR, 32'h2000, 32'h10, '0);
    applyRow(x);
endtask

task automatic buildTable();
    rows.push_back(aluRow(ADD, 32'd5, 32'd7, '0));
    rows.push_back(aluRow(SRA, 32'h8000_0000, 32'd4, '0));
    rows.push_back(aluRow(CLZ, 32'd1, '0, '0));
    rows.push_back(aluRow(CTZ, '0, '0, '0));
    rows.push_back(aluRow(CPOP, 32'hffff_ffff, '0, '0));
    rows.push_back(aluRow(REV8, 32'h1122_3344, '0, '0));
    rows.push_back(aluRow(SE_B, 32'h0000_0080, '0, '0));
    for (int k = 0; k < 2; k++) begin
        for (int o = 0; o <= int'(ZE_H); o++) begin
            rows.push_back(aluRow(IntOp'(o), $urandom, $urandom, $urandom));
        end
    end
    r = aluRow(SYS, '0, '0, 32'h0000_000a);
    r.fl = ResFlags'(4'ha);
    rows.push_back(r);
    r = aluRow(JAL, '0, '0, 32'h40);   // unpredicted jal trains the buffer.
    r.bt = 1'b1;
    r.btSrcExp = r.pc + 32'd2;
    r.dst = r.pc + 32'h40;
    rows.push_back(r);
    r = aluRow(JAL, '0, '0, 32'h80);
    r.c = 1'b1;
    r.data = r.pc + 32'd2;
    r.bt = 1'b1;
    r.btSrcExp = r.pc;
    r.dst = r.pc + 32'h80;
    rows.push_back(r);
    r = aluRow(JAL, '0, '0, 32'h40);
    r.pd = 1'b1;
    rows.push_back(r);
    r = aluRow(JALR, 32'h2000, 32'h10, '0);
    r.br = 1'b1;
    r.dst = 32'h2010;
    rows.push_back(r);
    addWindow(r.sq);
    for (int o = int'(BEQ); o <= int'(BGEU); o++) begin
        for (int p = 0; p < 3; p++) begin
            addBranch(IntOp'(o), 32'hffff_ffff, 32'd1, p != 2, p == 0);
            addBranch(IntOp'(o), 32'd5, 32'd5, p != 2, p == 0);
            addBranch(IntOp'(o), 32'd1, 32'hffff_ffff, p != 2, p == 0);
        end
    end
    r = aluRow(ADD, 32'd1, 32'd1, '0);
    r.inv = 1'b1;
    r.invSq = r.sq - 7'd1;
    r.acc = 1'b0;
    rows.push_back(r);
    r = aluRow(ADD, 32'd2, 32'd2, '0);
    r.inv = 1'b1;
    r.invSq = r.sq + 7'd1;
    rows.push_back(r);
    r = aluRow(OR, 32'd3, 32'd4, '0);
    r.stall = 1'b1;
    r.acc = 1'b0;
    rows.push_back(r);
    r = aluRow(OR, 32'd3, 32'd4, '0);
    r.en = 1'b0;
    r.acc = 1'b0;
    rows.push_back(r);
    r = aluRow(OR, 32'd3, 32'd4, '0);
    r.val = 1'b0;
    r.acc = 1'b0;
    rows.push_back(r);
    rows.push_back(aluRow(SUB, 32'd9, 32'd4, '0));
endtask

initial begin
    void'($urandom(91));
    rst = 1'b0;
    applyRedirect();   // issued while in reset.
    buildTable();
    limit = 2 * rows.size() + 20;
    repeat (2) @(negedge clk);
    rst = 1'b1;
    checkIdle();
    valid = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
        @(negedge clk);
        if (i > 0) checkRow(rows[i-1]);
        applyRow(rows[i]);
        #1 checkBit("wbReq", rows[i].val && rows[i].en, wbReq);
    end
    @(negedge clk);
    checkRow(rows[rows.size()-1]);
    applyRedirect();
    rst = 1'b0;   // reset while a redirect is issued.
    repeat (2) @(negedge clk);
    checkIdle();
    $display("All tests passed!");
    $finish;
end

endmodule

// ==== src.f ====
hw/coreTypesPkg.sv
hw/intOpPkg.sv
hw/intAlu.sv
hw/branchResolve.sv
hw/recoveryTimer.sv
hw/execCtrl.sv
hw/resultStage.sv
hw/intExecUnit.sv
sim/intExecUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module intExecUnitTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
